/* common/ex_params.svh */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data word
`define EX_WORD_W 32

// destination register address
`define EX_REG_ADDR_W 5

// shift amount from the low bits of reg1
`define EX_SHAMT_W 5

// operation code
`define EX_ALUOP_W 8

// result class
`define EX_ALUSEL_W 3

`endif

/* common/ex_pkg.sv */
`include "ex_params.svh"

package ex_pkg;

  // immediate forms arrive here as the register forms
  typedef enum logic [`EX_ALUOP_W-1:0] {
    OP_NOP   = 8'h00,
    OP_AND   = 8'h01,
    OP_OR    = 8'h02,
    OP_XOR   = 8'h03,
    OP_NOR   = 8'h04,
    OP_SLL   = 8'h10,
    OP_SRL   = 8'h11,
    OP_SRA   = 8'h12,
    OP_ADD   = 8'h20,
    OP_ADDU  = 8'h21,
    OP_SUB   = 8'h22,
    OP_SUBU  = 8'h23,
    OP_SLT   = 8'h24,
    OP_SLTU  = 8'h25,
    OP_CLZ   = 8'h26,
    OP_CLO   = 8'h27,
    OP_MUL   = 8'h30,
    OP_MULT  = 8'h31,
    OP_MULTU = 8'h32,
    OP_MFHI  = 8'h40,
    OP_MFLO  = 8'h41,
    OP_MTHI  = 8'h42,
    OP_MTLO  = 8'h43,
    OP_TEQ   = 8'h50,
    OP_TNE   = 8'h51,
    OP_TGE   = 8'h52,
    OP_TGEU  = 8'h53,
    OP_TLT   = 8'h54,
    OP_TLTU  = 8'h55
  } aluop_e;

  // which unit feeds the write-back word
  typedef enum logic [`EX_ALUSEL_W-1:0] {
    SEL_NOP   = 3'd0,
    SEL_LOGIC = 3'd1,
    SEL_SHIFT = 3'd2,
    SEL_ARITH = 3'd3,
    SEL_MOVE  = 3'd4,
    SEL_MUL   = 3'd5
  } alusel_e;

  typedef struct packed {
    aluop_e                    aluop;
    alusel_e                   alusel;
    logic [`EX_WORD_W-1:0]     reg1;
    logic [`EX_WORD_W-1:0]     reg2;
    logic                      wreg;
    logic [`EX_REG_ADDR_W-1:0] wd;
  } ex_op_t;

  typedef struct packed {
    logic                      wreg;
    logic [`EX_REG_ADDR_W-1:0] wd;
    logic [`EX_WORD_W-1:0]     wdata;
  } wb_t;

  typedef struct packed {
    logic                  whilo;
    logic [`EX_WORD_W-1:0] hi;
    logic [`EX_WORD_W-1:0] lo;
  } hilo_wr_t;

  typedef struct packed {
    logic ov;
    logic trap;
  } excpt_t;

endpackage

/* hw/ex/ex_alu.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_alu (
  input  ex_pkg::aluop_e         aluop_i,
  input  logic [`EX_WORD_W-1:0]  reg1_i,
  input  logic [`EX_WORD_W-1:0]  reg2_i,
  output logic [`EX_WORD_W-1:0]  logic_o,
  output logic [`EX_WORD_W-1:0]  shift_o,
  output logic [`EX_WORD_W-1:0]  arith_o,
  output logic                   ov_o,
  output logic                   trap_o
);
  import ex_pkg::*;

  localparam int W = `EX_WORD_W;

  logic                   sub_mode;
  logic                   signed_cmp;
  logic [W-1:0]           opb;
  logic [W:0]             sum_ext;
  logic [W-1:0]           sum;
  logic                   lt;
  logic [`EX_SHAMT_W-1:0] shamt;

  function automatic logic [W-1:0] clz(input logic [W-1:0] w);
    logic [W-1:0] cnt;
    logic         found;
    cnt   = W'(W);
    found = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      if (!found && w[i]) begin
        cnt   = W'(W - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  // one adder serves add, subtract and both compares
  assign sub_mode   = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
                                      OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
  assign signed_cmp = aluop_i inside {OP_SLT, OP_TGE, OP_TLT};
  assign opb        = sub_mode ? ~reg2_i : reg2_i;
  assign sum_ext    = {1'b0, reg1_i} + {1'b0, opb} + {{W{1'b0}}, sub_mode};
  assign sum        = sum_ext[W-1:0];

  // no carry out of a + ~b + 1 means unsigned a < b
  assign lt = signed_cmp ?
              ((reg1_i[W-1] & ~reg2_i[W-1]) |
               (~(reg1_i[W-1] ^ reg2_i[W-1]) & sum[W-1])) :
              ~sum_ext[W];

  assign ov_o = ((aluop_i == OP_ADD) || (aluop_i == OP_SUB)) &&
                (reg1_i[W-1] == opb[W-1]) && (sum[W-1] != reg1_i[W-1]);

  assign shamt = reg1_i[`EX_SHAMT_W-1:0];

  always_comb begin
    case (aluop_i)
      OP_AND:  logic_o = reg1_i & reg2_i;
      OP_OR:   logic_o = reg1_i | reg2_i;
      OP_XOR:  logic_o = reg1_i ^ reg2_i;
      OP_NOR:  logic_o = ~(reg1_i | reg2_i);
      default: logic_o = '0;
    endcase
  end

  always_comb begin
    case (aluop_i)
      OP_SLL:  shift_o = reg2_i << shamt;
      OP_SRL:  shift_o = reg2_i >> shamt;
      OP_SRA:  shift_o = $signed(reg2_i) >>> shamt;
      default: shift_o = '0;
    endcase
  end

  always_comb begin
    case (aluop_i)
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_o = sum;
      OP_SLT, OP_SLTU:                  arith_o = {{(W - 1){1'b0}}, lt};
      OP_CLZ:                           arith_o = clz(reg1_i);
      OP_CLO:                           arith_o = clz(~reg1_i);
      default:                          arith_o = '0;
    endcase
  end

  always_comb begin
    case (aluop_i)
      OP_TEQ:           trap_o = (reg1_i == reg2_i);
      OP_TNE:           trap_o = (reg1_i != reg2_i);
      OP_TGE, OP_TGEU:  trap_o = ~lt;
      OP_TLT, OP_TLTU:  trap_o = lt;
      default:          trap_o = 1'b0;
    endcase
  end

endmodule

/* hw/ex/ex_mul.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_mul (
  input  ex_pkg::aluop_e           aluop_i,
  input  logic [`EX_WORD_W-1:0]    reg1_i,
  input  logic [`EX_WORD_W-1:0]    reg2_i,
  output logic [2*`EX_WORD_W-1:0]  product_o
);
  import ex_pkg::*;

  localparam int W = `EX_WORD_W;

  logic           signed_op;
  logic [W-1:0]   mag1;
  logic [W-1:0]   mag2;
  logic [2*W-1:0] mag_prod;

  assign signed_op = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);

  // signed forms multiply magnitudes and restore the sign afterwards
  assign mag1     = (signed_op && reg1_i[W-1]) ? (~reg1_i + 1'b1) : reg1_i;
  assign mag2     = (signed_op && reg2_i[W-1]) ? (~reg2_i + 1'b1) : reg2_i;
  assign mag_prod = {{W{1'b0}}, mag1} * {{W{1'b0}}, mag2};

  always_comb begin
    case (aluop_i)
      OP_MULTU: product_o = mag_prod;
      OP_MUL, OP_MULT: begin
        product_o = (reg1_i[W-1] ^ reg2_i[W-1]) ? (~mag_prod + 1'b1) : mag_prod;
      end
      default: product_o = '0;
    endcase
  end

endmodule

/* hw/ex/ex_hilo.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_hilo (
  input  ex_pkg::aluop_e          aluop_i,
  input  logic [`EX_WORD_W-1:0]   reg1_i,
  input  logic [2*`EX_WORD_W-1:0] product_i,
  input  ex_pkg::hilo_wr_t        mem_hilo_i,
  input  logic [`EX_WORD_W-1:0]   hi_i,
  input  logic [`EX_WORD_W-1:0]   lo_i,
  output logic [`EX_WORD_W-1:0]   move_o,
  output ex_pkg::hilo_wr_t        hilo_wr_o
);
  import ex_pkg::*;

  localparam int W = `EX_WORD_W;

  logic [W-1:0] cur_hi;
  logic [W-1:0] cur_lo;

  // pending write in EX/MEM is newer than the register
  assign cur_hi = mem_hilo_i.whilo ? mem_hilo_i.hi : hi_i;
  assign cur_lo = mem_hilo_i.whilo ? mem_hilo_i.lo : lo_i;

  always_comb begin
    case (aluop_i)
      OP_MFHI: move_o = cur_hi;
      OP_MFLO: move_o = cur_lo;
      default: move_o = '0;
    endcase
  end

  always_comb begin
    hilo_wr_o = '0;
    case (aluop_i)
      OP_MULT, OP_MULTU: begin
        hilo_wr_o.whilo = 1'b1;
        hilo_wr_o.hi    = product_i[2*W-1:W];
        hilo_wr_o.lo    = product_i[W-1:0];
      end
      OP_MTHI: begin
        hilo_wr_o.whilo = 1'b1;
        hilo_wr_o.hi    = reg1_i;
        hilo_wr_o.lo    = cur_lo;
      end
      OP_MTLO: begin
        hilo_wr_o.whilo = 1'b1;
        hilo_wr_o.hi    = cur_hi;
        hilo_wr_o.lo    = reg1_i;
      end
      default: ;
    endcase
  end

endmodule

/* hw/ex/ex.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module ex (
  input  ex_pkg::ex_op_t         op_i,
  input  ex_pkg::hilo_wr_t       mem_hilo_i,
  input  logic [`EX_WORD_W-1:0]  hi_i,
  input  logic [`EX_WORD_W-1:0]  lo_i,
  output ex_pkg::wb_t            wb_o,
  output ex_pkg::hilo_wr_t       hilo_wr_o,
  output ex_pkg::excpt_t         excpt_o
);
  import ex_pkg::*;

  logic [`EX_WORD_W-1:0]   logic_res;
  logic [`EX_WORD_W-1:0]   shift_res;
  logic [`EX_WORD_W-1:0]   arith_res;
  logic [`EX_WORD_W-1:0]   move_res;
  logic [2*`EX_WORD_W-1:0] product;
  logic                    ov;
  logic                    trap;

  ex_alu u_alu (
    .aluop_i (op_i.aluop),
    .reg1_i  (op_i.reg1),
    .reg2_i  (op_i.reg2),
    .logic_o (logic_res),
    .shift_o (shift_res),
    .arith_o (arith_res),
    .ov_o    (ov),
    .trap_o  (trap)
  );

  ex_mul u_mul (
    .aluop_i   (op_i.aluop),
    .reg1_i    (op_i.reg1),
    .reg2_i    (op_i.reg2),
    .product_o (product)
  );

  ex_hilo u_hilo (
    .aluop_i    (op_i.aluop),
    .reg1_i     (op_i.reg1),
    .product_i  (product),
    .mem_hilo_i (mem_hilo_i),
    .hi_i       (hi_i),
    .lo_i       (lo_i),
    .move_o     (move_res),
    .hilo_wr_o  (hilo_wr_o)
  );

  always_comb begin
    case (op_i.alusel)
      SEL_LOGIC: wb_o.wdata = logic_res;
      SEL_SHIFT: wb_o.wdata = shift_res;
      SEL_ARITH: wb_o.wdata = arith_res;
      SEL_MOVE:  wb_o.wdata = move_res;
      SEL_MUL:   wb_o.wdata = product[`EX_WORD_W-1:0];
      default:   wb_o.wdata = '0;
    endcase
  end

  // overflowing add/sub must not reach the register file
  assign wb_o.wreg     = op_i.wreg & ~ov;
  assign wb_o.wd       = op_i.wd;
  assign excpt_o.ov    = ov;
  assign excpt_o.trap  = trap;

endmodule

/* hw/ex_mem.sv */
`timescale 1ns/1ps

module ex_mem (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  ex_pkg::wb_t      wb_i,
  input  ex_pkg::hilo_wr_t hilo_i,
  input  ex_pkg::excpt_t   excpt_i,
  output ex_pkg::wb_t      wb_o,
  output ex_pkg::hilo_wr_t hilo_o,
  output ex_pkg::excpt_t   excpt_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_o    <= '0;
      hilo_o  <= '0;
      excpt_o <= '0;
    end else begin
      wb_o    <= wb_i;
      hilo_o  <= hilo_i;
      excpt_o <= excpt_i;
    end
  end

endmodule

/* hw/hilo_reg.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module hilo_reg (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ex_pkg::hilo_wr_t      wr_i,
  output logic [`EX_WORD_W-1:0] hi_o,
  output logic [`EX_WORD_W-1:0] lo_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hi_o <= '0;
      lo_o <= '0;
    end else if (wr_i.whilo) begin
      hi_o <= wr_i.hi;
      lo_o <= wr_i.lo;
    end
  end

endmodule

/* hw/ex_unit_top.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_unit_top (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  ex_pkg::ex_op_t   op_i,
  output ex_pkg::wb_t      wb_o,
  output ex_pkg::hilo_wr_t hilo_o,
  output ex_pkg::excpt_t   excpt_o
);
  import ex_pkg::*;

  wb_t                   ex_wb;
  hilo_wr_t              ex_hilo_wr;
  excpt_t                ex_excpt;
  logic [`EX_WORD_W-1:0] hi;
  logic [`EX_WORD_W-1:0] lo;

  ex u_ex (
    .op_i       (op_i),
    .mem_hilo_i (hilo_o),
    .hi_i       (hi),
    .lo_i       (lo),
    .wb_o       (ex_wb),
    .hilo_wr_o  (ex_hilo_wr),
    .excpt_o    (ex_excpt)
  );

  // registered hilo write also feeds forwarding back into ex
  ex_mem u_ex_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_i     (ex_wb),
    .hilo_i   (ex_hilo_wr),
    .excpt_i  (ex_excpt),
    .wb_o     (wb_o),
    .hilo_o   (hilo_o),
    .excpt_o  (excpt_o)
  );

  hilo_reg u_hilo_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wr_i     (hilo_o),
    .hi_o     (hi),
    .lo_o     (lo)
  );

endmodule

/* bench/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

typedef struct packed {
  wb_t      wb;
  hilo_wr_t hilo;
  excpt_t   excpt;
} expect_t;

// HI/LO after every write issued so far
logic [`EX_WORD_W-1:0] model_hi;
logic [`EX_WORD_W-1:0] model_lo;

function automatic logic [31:0] lead_count(input logic [31:0] w, input logic val);
  logic [31:0] n;
  logic        stop;
  n    = '0;
  stop = 1'b0;
  for (int i = 31; i >= 0; i--) begin
    if (w[i] != val)
      stop = 1'b1;
    if (!stop)
      n = n + 1;
  end
  return n;
endfunction

function automatic expect_t ref_calc(input ex_op_t op, input logic [31:0] hi,
                                     input logic [31:0] lo);
  expect_t            e;
  logic [31:0]        a;
  logic [31:0]        b;
  logic [31:0]        res;
  logic signed [63:0] wide;
  logic [63:0]        prod;
  e    = '0;
  a    = op.reg1;
  b    = op.reg2;
  res  = '0;
  wide = '0;
  // sign-extended operands give the signed product modulo 2^64
  prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
  if (op.aluop == OP_MULTU)
    prod = {32'b0, a} * {32'b0, b};
  case (op.aluop)
    OP_AND:  res = a & b;
    OP_OR:   res = a | b;
    OP_XOR:  res = a ^ b;
    OP_NOR:  res = ~(a | b);
    OP_SLL:  res = b << a[4:0];
    OP_SRL:  res = b >> a[4:0];
    OP_SRA:  res = $unsigned($signed(b) >>> a[4:0]);
    OP_ADD, OP_ADDU: begin
      res  = a + b;
      wide = $signed({{32{a[31]}}, a}) + $signed({{32{b[31]}}, b});
    end
    OP_SUB, OP_SUBU: begin
      res  = a - b;
      wide = $signed({{32{a[31]}}, a}) - $signed({{32{b[31]}}, b});
    end
    OP_SLT:  res = {31'b0, $signed(a) < $signed(b)};
    OP_SLTU: res = {31'b0, a < b};
    OP_CLZ:  res = lead_count(a, 1'b0);
    OP_CLO:  res = lead_count(a, 1'b1);
    OP_MUL:  res = prod[31:0];
    OP_MFHI: res = hi;
    OP_MFLO: res = lo;
    OP_TEQ:  e.excpt.trap = (a == b);
    OP_TNE:  e.excpt.trap = (a != b);
    OP_TGE:  e.excpt.trap = ($signed(a) >= $signed(b));
    OP_TGEU: e.excpt.trap = (a >= b);
    OP_TLT:  e.excpt.trap = ($signed(a) < $signed(b));
    OP_TLTU: e.excpt.trap = (a < b);
    OP_MULT, OP_MULTU: e.hilo = {1'b1, prod};
    OP_MTHI: e.hilo = {1'b1, a, lo};
    OP_MTLO: e.hilo = {1'b1, hi, a};
    default: ;
  endcase
  // true result outside the 32-bit signed range
  e.excpt.ov = (op.aluop inside {OP_ADD, OP_SUB}) &&
               ((wide > 64'sh7fff_ffff) || (wide < -64'sh8000_0000));
  e.wb.wreg  = op.wreg & ~e.excpt.ov;
  e.wb.wd    = op.wd;
  e.wb.wdata = (op.alusel == SEL_NOP) ? '0 : res;
  return e;
endfunction

task automatic model_commit(input hilo_wr_t w);
  if (w.whilo) begin
    model_hi = w.hi;
    model_lo = w.lo;
  end
endtask

`endif

/* bench/tb_ex_unit.sv */
`timescale 1ns/1ps
`include "ex_params.svh"

module tb_ex_unit;
  import ex_pkg::*;

  `include "ex_ref_model.svh"

  logic     clk_i;
  logic     arst_n_i;
  ex_op_t   op_i;
  wb_t      wb_o;
  hilo_wr_t hilo_o;
  excpt_t   excpt_o;

  integer   seed;
  int       err_cnt;
  int       chk_cnt;
  expect_t  exp_q[$];
  expect_t  pend;
  logic     pend_vld;
  logic     timed_out;
  aluop_e   rand_ops [22];
  aluop_e   trap_ops [6];

  ex_unit_top uut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .op_i     (op_i),
    .wb_o     (wb_o),
    .hilo_o   (hilo_o),
    .excpt_o  (excpt_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic ex_op_t make_op(input aluop_e op, input logic [31:0] r1,
                                     input logic [31:0] r2);
    ex_op_t o;
    o.aluop = op;
    o.reg1  = r1;
    o.reg2  = r2;
    o.wd    = r1[9:5] ^ r2[4:0];
    if (op inside {OP_AND, OP_OR, OP_XOR, OP_NOR})
      o.alusel = SEL_LOGIC;
    else if (op inside {OP_SLL, OP_SRL, OP_SRA})
      o.alusel = SEL_SHIFT;
    else if (op inside {OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO})
      o.alusel = SEL_ARITH;
    else if (op inside {OP_MFHI, OP_MFLO})
      o.alusel = SEL_MOVE;
    else if (op == OP_MUL)
      o.alusel = SEL_MUL;
    else
      o.alusel = SEL_NOP;
    o.wreg = (o.alusel != SEL_NOP);
    return o;
  endfunction

  task automatic issue(input aluop_e op, input logic [31:0] r1, input logic [31:0] r2);
    ex_op_t  o;
    expect_t e;
    o = make_op(op, r1, r2);
    e = ref_calc(o, model_hi, model_lo);
    @(posedge clk_i);
    op_i <= o;
    exp_q.push_back(e);
    model_commit(e.hilo);
  endtask

  // op driven at one rising edge is checked after the next one
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      if (wb_o.wreg !== 1'b0 || hilo_o.whilo !== 1'b0 ||
          excpt_o.ov !== 1'b0 || excpt_o.trap !== 1'b0) begin
        $display("ERROR %0t: control flags set during reset", $time);
        err_cnt++;
      end
    end else begin
      if (pend_vld) begin
        chk_cnt++;
        if (wb_o !== pend.wb) begin
          $display("ERROR %0t: wb expected %h got %h", $time, pend.wb, wb_o);
          err_cnt++;
        end
        if (hilo_o !== pend.hilo) begin
          $display("ERROR %0t: hilo expected %h got %h", $time, pend.hilo, hilo_o);
          err_cnt++;
        end
        if (excpt_o !== pend.excpt) begin
          $display("ERROR %0t: excpt expected %b got %b", $time, pend.excpt, excpt_o);
          err_cnt++;
        end
      end
      pend_vld = (exp_q.size() != 0);
      if (pend_vld)
        pend = exp_q.pop_front();
    end
  end

  initial begin
    int          wait_cnt;
    logic [31:0] a;
    logic [31:0] b;
    aluop_e      op;
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    op_i      = '0;
    seed      = 60436;
    err_cnt   = 0;
    chk_cnt   = 0;
    pend_vld  = 1'b0;
    timed_out = 1'b0;
    model_hi  = '0;
    model_lo  = '0;
    rand_ops  = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_ADD,
                  OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_MUL,
                  OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO};
    trap_ops  = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (3) issue(OP_NOP, '0, '0);

    // mixed random traffic with HI/LO movers
    for (int i = 0; i < 400; i++) begin
      a  = $random(seed);
      b  = $random(seed);
      op = rand_ops[$unsigned($random(seed)) % 22];
      if (op == OP_CLZ)
        a = a >> b[4:0];
      if (op == OP_CLO)
        a = ~(a >> b[4:0]);
      issue(op, a, b);
    end

    issue(OP_ADD,  32'h7fff_ffff, 32'h0000_0001);
    issue(OP_ADD,  32'h8000_0000, 32'hffff_ffff);
    issue(OP_SUB,  32'h8000_0000, 32'h0000_0001);
    issue(OP_SUB,  32'h7fff_ffff, 32'hffff_ffff);
    issue(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
    issue(OP_SUBU, 32'h8000_0000, 32'h0000_0001);
    issue(OP_CLZ,  32'h0000_0000, 32'h0);
    issue(OP_CLO,  32'hffff_ffff, 32'h0);
    issue(OP_MUL,   32'hffff_fff6, 32'h0000_0007);
    issue(OP_MULT,  32'h8000_0000, 32'h7fff_ffff);
    issue(OP_MULTU, 32'hffff_fff6, 32'h0000_0007);

    // forwarding from EX/MEM and then from the committed HI/LO
    issue(OP_MTHI, 32'hdead_0001, '0);
    issue(OP_MFHI, '0, '0);
    issue(OP_MTLO, 32'hbeef_0002, '0);
    issue(OP_MFHI, '0, '0);
    issue(OP_MULT, 32'hffff_1234, 32'h0000_5678);
    issue(OP_MFLO, '0, '0);
    issue(OP_MTHI, 32'h1357_9bdf, '0);
    issue(OP_NOP, '0, '0);
    issue(OP_MFHI, '0, '0);
    issue(OP_MFLO, '0, '0);

    foreach (trap_ops[k]) begin
      issue(trap_ops[k], 32'h1234_5678, 32'h1234_5678);
      issue(trap_ops[k], 32'hffff_fff0, 32'h0000_0005);
      issue(trap_ops[k], 32'h0000_0005, 32'hffff_fff0);
      issue(trap_ops[k], 32'h9000_0000, 32'h0000_0010);
    end
    repeat (2) issue(OP_NOP, '0, '0);

    wait_cnt = 0;
    while ((exp_q.size() != 0 || pend_vld) && wait_cnt < 10) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    timed_out = (exp_q.size() != 0) || pend_vld;
    if (timed_out)
      $display("timeout: results still outstanding after the last operation");
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+common
+incdir+bench
common/ex_pkg.sv
hw/ex/ex_alu.sv
hw/ex/ex_mul.sv
hw/ex/ex_hilo.sv
hw/ex/ex.sv
hw/ex_mem.sv
hw/hilo_reg.sv
hw/ex_unit_top.sv
bench/tb_ex_unit.sv
